// File: riscv_pkg.sv
`default_nettype none

package riscv_pkg;

  // datapath width and register address width.
  localparam int XLEN       = 64;
  localparam int REG_ADDR_W = 5;

  // control field widths as seen at the stage inputs.
  localparam int ALU_CTRL_W = 6;
  localparam int BR_OP_W    = 4;

  // bit 5 enables the alu, bits 4:0 pick the operation.
  typedef enum logic [ALU_CTRL_W-1:0] {
    ALU_OFF = 6'b000000,
    ADD     = 6'b100000,
    SUB     = 6'b100001,
    SLL     = 6'b100010,
    SLT     = 6'b100011,
    SLTU    = 6'b100100,
    XOR     = 6'b100101,
    SRL     = 6'b100110,
    SRA     = 6'b100111,
    OR      = 6'b101000,
    AND     = 6'b101001,
    JALR    = 6'b101010,
    ADDW    = 6'b110000,
    SUBW    = 6'b110001,
    SLLW    = 6'b110010,
    SRLW    = 6'b110110,
    SRAW    = 6'b110111
  } alu_op_e;

  // branch and jump kinds resolved in execute.
  typedef enum logic [BR_OP_W-1:0] {
    BR_NONE = 4'd0,
    BR_BEQ  = 4'd1,
    BR_BNE  = 4'd2,
    BR_BLT  = 4'd3,
    BR_BGE  = 4'd4,
    BR_BLTU = 4'd5,
    BR_BGEU = 4'd6,
    BR_JAL  = 4'd7,
    BR_JALR = 4'd8
  } branch_op_e;

endpackage

`default_nettype wire

// File: riscv_ex_mem_if.sv
`timescale 1ns/1ps
`default_nettype none

interface riscv_ex_mem_if import riscv_pkg::*; ();

  logic                  valid;
  logic [REG_ADDR_W-1:0] rd_addr;
  logic                  rd_wr;
  logic [XLEN-1:0]       result;

  // the pipeline register owns the bundle.
  modport src (
    output valid,
    output rd_addr,
    output rd_wr,
    output result
  );

  // forwarding only looks at it.
  modport fwd (
    input valid,
    input rd_addr,
    input rd_wr,
    input result
  );

endinterface

`default_nettype wire

// File: riscv_alu.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_alu
  import riscv_pkg::*;
(
  input  wire alu_op_e                i_riscv_alu_ctrl,
  input  wire logic signed [XLEN-1:0] i_riscv_alu_rs1data,
  input  wire logic signed [XLEN-1:0] i_riscv_alu_rs2data,
  output logic signed [XLEN-1:0]      o_riscv_alu_result
);

  logic        [5:0]      shamt;
  logic        [XLEN-1:0] jalr_sum;
  logic        [31:0]     word_res;
  logic signed [31:0]     rs1_word;

  assign shamt    = i_riscv_alu_rs2data[5:0];
  assign rs1_word = i_riscv_alu_rs1data[31:0];
  assign jalr_sum = i_riscv_alu_rs1data + i_riscv_alu_rs2data;

  // low word of the w operations, sign extended below.
  always_comb begin
    word_res = '0;
    case (i_riscv_alu_ctrl)
      ADDW: begin
        word_res = i_riscv_alu_rs1data[31:0] + i_riscv_alu_rs2data[31:0];
      end
      SUBW: begin
        word_res = i_riscv_alu_rs1data[31:0] - i_riscv_alu_rs2data[31:0];
      end
      SLLW: begin
        word_res = i_riscv_alu_rs1data[31:0] << shamt[4:0];
      end
      SRLW: begin
        word_res = i_riscv_alu_rs1data[31:0] >> shamt[4:0];
      end
      SRAW: begin
        word_res = rs1_word >>> shamt[4:0];
      end
      default: begin
        word_res = '0;
      end
    endcase
  end

  // alu_off, a clear enable bit and unknown codes all fall to zero.
  always_comb begin
    o_riscv_alu_result = '0;
    case (i_riscv_alu_ctrl)
      ADD: begin
        o_riscv_alu_result = i_riscv_alu_rs1data + i_riscv_alu_rs2data;
      end
      SUB: begin
        o_riscv_alu_result = i_riscv_alu_rs1data - i_riscv_alu_rs2data;
      end
      SLL: begin
        o_riscv_alu_result = i_riscv_alu_rs1data << shamt;
      end
      SLT: begin
        o_riscv_alu_result = (i_riscv_alu_rs1data < i_riscv_alu_rs2data) ? 64'd1 : 64'd0;
      end
      SLTU: begin
        o_riscv_alu_result = ($unsigned(i_riscv_alu_rs1data) < $unsigned(i_riscv_alu_rs2data))
                             ? 64'd1 : 64'd0;
      end
      XOR: begin
        o_riscv_alu_result = i_riscv_alu_rs1data ^ i_riscv_alu_rs2data;
      end
      SRL: begin
        o_riscv_alu_result = i_riscv_alu_rs1data >> shamt;
      end
      SRA: begin
        o_riscv_alu_result = i_riscv_alu_rs1data >>> shamt;
      end
      OR: begin
        o_riscv_alu_result = i_riscv_alu_rs1data | i_riscv_alu_rs2data;
      end
      AND: begin
        o_riscv_alu_result = i_riscv_alu_rs1data & i_riscv_alu_rs2data;
      end
      JALR: begin
        // jump target, halfword aligned.
        o_riscv_alu_result = {jalr_sum[XLEN-1:1], 1'b0};
      end
      ADDW, SUBW, SLLW, SRLW, SRAW: begin
        o_riscv_alu_result = {{32{word_res[31]}}, word_res};
      end
      default: begin
        o_riscv_alu_result = '0;
      end
    endcase
  end

  a_jalr_aligned: assert final (i_riscv_alu_ctrl != JALR || o_riscv_alu_result[0] == 1'b0)
    else $error("jalr result has bit 0 set");

endmodule

`default_nettype wire

// File: riscv_forward_unit.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_forward_unit
  import riscv_pkg::*;
(
  input  wire logic [REG_ADDR_W-1:0] i_rs1_addr,
  input  wire logic [REG_ADDR_W-1:0] i_rs2_addr,
  input  wire logic [XLEN-1:0]       i_rs1_data,
  input  wire logic [XLEN-1:0]       i_rs2_data,
  input  wire logic [XLEN-1:0]       i_imm,
  input  wire logic                  i_use_imm,
  input  wire logic [REG_ADDR_W-1:0] i_wb_rd_addr,
  input  wire logic [XLEN-1:0]       i_wb_result,
  input  wire logic                  i_wb_wr,
  riscv_ex_mem_if.fwd                ex_mem,
  output logic [XLEN-1:0]            o_rs1_val,
  output logic [XLEN-1:0]            o_rs2_val,
  output logic [XLEN-1:0]            o_op_b
);

  logic ex_wr_ok;

  assign ex_wr_ok = ex_mem.valid && ex_mem.rd_wr;

  // ex/mem is younger than write-back so it is checked first.
  function automatic logic [XLEN-1:0] pick_operand(
    input logic [REG_ADDR_W-1:0] addr,
    input logic [XLEN-1:0]       rf_data
  );
    if (addr == '0) begin
      return rf_data;
    end else if (ex_wr_ok && addr == ex_mem.rd_addr) begin
      return ex_mem.result;
    end else if (i_wb_wr && addr == i_wb_rd_addr) begin
      return i_wb_result;
    end
    return rf_data;
  endfunction

  always_comb begin
    o_rs1_val = pick_operand(i_rs1_addr, i_rs1_data);
    o_rs2_val = pick_operand(i_rs2_addr, i_rs2_data);
  end

  assign o_op_b = i_use_imm ? i_imm : o_rs2_val;

  a_no_x0_fwd: assert final ((i_rs1_addr != '0 || o_rs1_val == i_rs1_data) &&
                             (i_rs2_addr != '0 || o_rs2_val == i_rs2_data))
    else $error("register x0 was forwarded");

endmodule

`default_nettype wire

// File: riscv_branch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_branch_unit
  import riscv_pkg::*;
(
  input  wire branch_op_e       i_branch_op,
  input  wire logic [XLEN-1:0]  i_pc,
  input  wire logic [XLEN-1:0]  i_rs1_val,
  input  wire logic [XLEN-1:0]  i_rs2_val,
  input  wire logic [XLEN-1:0]  i_imm,
  input  wire logic [XLEN-1:0]  i_alu_result,
  output logic                  o_taken,
  output logic [XLEN-1:0]       o_target,
  output logic [XLEN-1:0]       o_link,
  output logic                  o_is_jump
);

  logic eq;
  logic lt_s;
  logic lt_u;

  assign eq   = (i_rs1_val == i_rs2_val);
  assign lt_s = ($signed(i_rs1_val) < $signed(i_rs2_val));
  assign lt_u = (i_rs1_val < i_rs2_val);

  always_comb begin
    case (i_branch_op)
      BR_BEQ:  o_taken = eq;
      BR_BNE:  o_taken = !eq;
      BR_BLT:  o_taken = lt_s;
      BR_BGE:  o_taken = !lt_s;
      BR_BLTU: o_taken = lt_u;
      BR_BGEU: o_taken = !lt_u;
      BR_JAL:  o_taken = 1'b1;
      BR_JALR: o_taken = 1'b1;
      default: o_taken = 1'b0;
    endcase
  end

  assign o_is_jump = (i_branch_op == BR_JAL) || (i_branch_op == BR_JALR);

  // jalr takes the aligned sum from the alu.
  assign o_target = (i_branch_op == BR_JALR) ? i_alu_result : i_pc + i_imm;
  assign o_link   = i_pc + 64'd4;

endmodule

`default_nettype wire

// File: riscv_ex_mem_reg.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_ex_mem_reg
  import riscv_pkg::*;
(
  input  wire logic                  i_clk,
  input  wire logic                  i_rst,
  input  wire logic                  i_valid,
  input  wire logic                  i_stall,
  input  wire logic                  i_flush,
  input  wire logic [REG_ADDR_W-1:0] i_rd_addr,
  input  wire logic                  i_rd_wr,
  input  wire logic [XLEN-1:0]       i_alu_result,
  input  wire logic [XLEN-1:0]       i_link,
  input  wire logic                  i_is_jump,
  input  wire logic                  i_taken,
  input  wire logic [XLEN-1:0]       i_target,
  riscv_ex_mem_if.src                ex_mem,
  output logic                       o_redirect,
  output logic [XLEN-1:0]            o_target
);

  logic accept;

  // the slot after a taken branch holds a wrong-path instruction.
  assign accept = i_valid && !o_redirect;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      ex_mem.valid <= 1'b0;
      ex_mem.rd_wr <= 1'b0;
      o_redirect   <= 1'b0;
    end else if (i_flush) begin
      ex_mem.valid <= 1'b0;
      ex_mem.rd_wr <= 1'b0;
      o_redirect   <= 1'b0;
    end else if (!i_stall) begin
      ex_mem.valid <= accept;
      ex_mem.rd_wr <= accept && i_rd_wr;
      o_redirect   <= accept && i_taken;
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_stall) begin
      ex_mem.rd_addr <= i_rd_addr;
      ex_mem.result  <= i_is_jump ? i_link : i_alu_result;
      o_target       <= i_target;
    end
  end

  a_redirect_valid: assert property (@(posedge i_clk) disable iff (i_rst)
    o_redirect |-> ex_mem.valid)
    else $error("redirect without a valid instruction");

  a_stall_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    (i_stall && !i_flush) |=> $stable(ex_mem.valid) && $stable(ex_mem.rd_wr) &&
                               $stable(ex_mem.rd_addr) && $stable(ex_mem.result) &&
                               $stable(o_redirect) && $stable(o_target))
    else $error("registered outputs changed during stall");

endmodule

`default_nettype wire

// File: riscv_execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_execute_stage
  import riscv_pkg::*;
(
  input  wire logic                  i_clk,
  input  wire logic                  i_rst,
  input  wire logic                  i_valid,
  input  wire logic [ALU_CTRL_W-1:0] i_alu_ctrl,
  input  wire logic [BR_OP_W-1:0]    i_branch_op,
  input  wire logic [XLEN-1:0]       i_pc,
  input  wire logic [XLEN-1:0]       i_rs1_data,
  input  wire logic [XLEN-1:0]       i_rs2_data,
  input  wire logic [XLEN-1:0]       i_imm,
  input  wire logic                  i_use_imm,
  input  wire logic [REG_ADDR_W-1:0] i_rs1_addr,
  input  wire logic [REG_ADDR_W-1:0] i_rs2_addr,
  input  wire logic [REG_ADDR_W-1:0] i_rd_addr,
  input  wire logic                  i_rd_wr,
  input  wire logic [REG_ADDR_W-1:0] i_wb_rd_addr,
  input  wire logic [XLEN-1:0]       i_wb_result,
  input  wire logic                  i_wb_wr,
  input  wire logic                  i_stall,
  input  wire logic                  i_flush,
  output logic                       o_valid,
  output logic [REG_ADDR_W-1:0]      o_rd_addr,
  output logic                       o_rd_wr,
  output logic [XLEN-1:0]            o_result,
  output logic                       o_redirect,
  output logic [XLEN-1:0]            o_target
);

  logic [XLEN-1:0] rs1_val;
  logic [XLEN-1:0] rs2_val;
  logic [XLEN-1:0] op_b;
  logic [XLEN-1:0] alu_result;
  logic [XLEN-1:0] br_target;
  logic [XLEN-1:0] link;
  logic            taken;
  logic            is_jump;

  riscv_ex_mem_if ex_mem_bus ();

  riscv_forward_unit forward_i (
    .i_rs1_addr   (i_rs1_addr),
    .i_rs2_addr   (i_rs2_addr),
    .i_rs1_data   (i_rs1_data),
    .i_rs2_data   (i_rs2_data),
    .i_imm        (i_imm),
    .i_use_imm    (i_use_imm),
    .i_wb_rd_addr (i_wb_rd_addr),
    .i_wb_result  (i_wb_result),
    .i_wb_wr      (i_wb_wr),
    .ex_mem       (ex_mem_bus.fwd),
    .o_rs1_val    (rs1_val),
    .o_rs2_val    (rs2_val),
    .o_op_b       (op_b)
  );

  riscv_alu alu_i (
    .i_riscv_alu_ctrl    (alu_op_e'(i_alu_ctrl)),
    .i_riscv_alu_rs1data (rs1_val),
    .i_riscv_alu_rs2data (op_b),
    .o_riscv_alu_result  (alu_result)
  );

  riscv_branch_unit branch_i (
    .i_branch_op  (branch_op_e'(i_branch_op)),
    .i_pc         (i_pc),
    .i_rs1_val    (rs1_val),
    .i_rs2_val    (rs2_val),
    .i_imm        (i_imm),
    .i_alu_result (alu_result),
    .o_taken      (taken),
    .o_target     (br_target),
    .o_link       (link),
    .o_is_jump    (is_jump)
  );

  riscv_ex_mem_reg ex_mem_reg_i (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_valid      (i_valid),
    .i_stall      (i_stall),
    .i_flush      (i_flush),
    .i_rd_addr    (i_rd_addr),
    .i_rd_wr      (i_rd_wr),
    .i_alu_result (alu_result),
    .i_link       (link),
    .i_is_jump    (is_jump),
    .i_taken      (taken),
    .i_target     (br_target),
    .ex_mem       (ex_mem_bus.src),
    .o_redirect   (o_redirect),
    .o_target     (o_target)
  );

  assign o_valid   = ex_mem_bus.valid;
  assign o_rd_addr = ex_mem_bus.rd_addr;
  assign o_rd_wr   = ex_mem_bus.rd_wr;
  assign o_result  = ex_mem_bus.result;

endmodule

`default_nettype wire

// File: tb_riscv_execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_riscv_execute_stage import riscv_pkg::*; ();

  // roughly twice the cycles the directed tests need.
  localparam int MAX_CYCLES = 400;

  logic                  i_clk;
  logic                  i_rst;
  logic                  i_valid;
  logic [ALU_CTRL_W-1:0] i_alu_ctrl;
  logic [BR_OP_W-1:0]    i_branch_op;
  logic [XLEN-1:0]       i_pc;
  logic [XLEN-1:0]       i_rs1_data;
  logic [XLEN-1:0]       i_rs2_data;
  logic [XLEN-1:0]       i_imm;
  logic                  i_use_imm;
  logic [REG_ADDR_W-1:0] i_rs1_addr;
  logic [REG_ADDR_W-1:0] i_rs2_addr;
  logic [REG_ADDR_W-1:0] i_rd_addr;
  logic                  i_rd_wr;
  logic [REG_ADDR_W-1:0] i_wb_rd_addr;
  logic [XLEN-1:0]       i_wb_result;
  logic                  i_wb_wr;
  logic                  i_stall;
  logic                  i_flush;
  logic                  o_valid;
  logic [REG_ADDR_W-1:0] o_rd_addr;
  logic                  o_rd_wr;
  logic [XLEN-1:0]       o_result;
  logic                  o_redirect;
  logic [XLEN-1:0]       o_target;

  logic [31:0] seed;
  int          errors;
  int          checks;
  int          cycles;

  riscv_execute_stage dut_i (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_valid      (i_valid),
    .i_alu_ctrl   (i_alu_ctrl),
    .i_branch_op  (i_branch_op),
    .i_pc         (i_pc),
    .i_rs1_data   (i_rs1_data),
    .i_rs2_data   (i_rs2_data),
    .i_imm        (i_imm),
    .i_use_imm    (i_use_imm),
    .i_rs1_addr   (i_rs1_addr),
    .i_rs2_addr   (i_rs2_addr),
    .i_rd_addr    (i_rd_addr),
    .i_rd_wr      (i_rd_wr),
    .i_wb_rd_addr (i_wb_rd_addr),
    .i_wb_result  (i_wb_result),
    .i_wb_wr      (i_wb_wr),
    .i_stall      (i_stall),
    .i_flush      (i_flush),
    .o_valid      (o_valid),
    .o_rd_addr    (o_rd_addr),
    .o_rd_wr      (o_rd_wr),
    .o_result     (o_result),
    .o_redirect   (o_redirect),
    .o_target     (o_target)
  );

  initial begin
    i_clk = 1'b0;
    forever #50 i_clk = ~i_clk;
  end

  function automatic logic [31:0] lcg(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic rand64(output logic [63:0] r);
    seed = lcg(seed);
    r[63:32] = seed;
    seed = lcg(seed);
    r[31:0] = seed;
  endtask

  // reference rules for the alu, written out per operation.
  function automatic logic [63:0] alu_model(input logic [5:0] ctrl, input logic [63:0] a,
                                            input logic [63:0] b);
    logic [5:0]  sh;
    logic [31:0] w;
    logic [63:0] r;
    logic        word;
    sh = b[5:0];
    w = '0;
    r = '0;
    word = 1'b0;
    case (ctrl)
      ADD:  r = a + b;
      SUB:  r = a + ~b + 64'd1;
      SLL:  r = a << sh;
      SLT:  r = {63'd0, (a[63] != b[63]) ? a[63] : (a < b)};
      SLTU: r = {63'd0, a < b};
      XOR:  r = a ^ b;
      SRL:  r = a >> sh;
      SRA:  r = (a >> sh) | (a[63] ? ~(64'hffff_ffff_ffff_ffff >> sh) : 64'd0);
      OR:   r = a | b;
      AND:  r = a & b;
      JALR: r = (a + b) & ~64'd1;
      ADDW: begin
        w = a[31:0] + b[31:0];
        word = 1'b1;
      end
      SUBW: begin
        w = a[31:0] - b[31:0];
        word = 1'b1;
      end
      SLLW: begin
        w = a[31:0] << sh[4:0];
        word = 1'b1;
      end
      SRLW: begin
        w = a[31:0] >> sh[4:0];
        word = 1'b1;
      end
      SRAW: begin
        w = (a[31:0] >> sh[4:0]) | (a[31] ? ~(32'hffff_ffff >> sh[4:0]) : 32'd0);
        word = 1'b1;
      end
      default: r = '0;
    endcase
    if (word) begin
      r = {{32{w[31]}}, w};
    end
    return r;
  endfunction

  // signed compare done by flipping the sign bits.
  function automatic logic branch_model(input logic [3:0] op, input logic [63:0] a,
                                        input logic [63:0] b);
    logic [63:0] sa;
    logic [63:0] sb;
    sa = a ^ 64'h8000_0000_0000_0000;
    sb = b ^ 64'h8000_0000_0000_0000;
    case (op)
      BR_BEQ:  return a == b;
      BR_BNE:  return a != b;
      BR_BLT:  return sa < sb;
      BR_BGE:  return sa >= sb;
      BR_BLTU: return a < b;
      BR_BGEU: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("mismatch at %0t ns: %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic issue(input logic [5:0] ctrl, input logic [3:0] br, input logic [63:0] pc,
                       input logic [63:0] a, input logic [63:0] b, input logic [63:0] imm,
                       input logic use_imm, input logic [4:0] rs1a, input logic [4:0] rs2a,
                       input logic [4:0] rda);
    @(posedge i_clk);
    i_valid     <= 1'b1;
    i_alu_ctrl  <= ctrl;
    i_branch_op <= br;
    i_pc        <= pc;
    i_rs1_data  <= a;
    i_rs2_data  <= b;
    i_imm       <= imm;
    i_use_imm   <= use_imm;
    i_rs1_addr  <= rs1a;
    i_rs2_addr  <= rs2a;
    i_rd_addr   <= rda;
    i_rd_wr     <= 1'b1;
  endtask

  task automatic idle();
    @(posedge i_clk);
    i_valid     <= 1'b0;
    i_alu_ctrl  <= ALU_OFF;
    i_branch_op <= BR_NONE;
    i_rd_wr     <= 1'b0;
    i_wb_wr     <= 1'b0;
  endtask

  task automatic alu_once(input logic [5:0] ctrl, input logic [63:0] a, input logic [63:0] b,
                          input logic [63:0] imm, input logic use_imm, input logic [63:0] exp);
    issue(ctrl, BR_NONE, 64'd0, a, b, imm, use_imm, 5'd1, 5'd2, 5'd3);
    idle();
    @(negedge i_clk);
    compare("o_result", exp, o_result);
    compare("o_valid", 64'd1, o_valid);
  endtask

  task automatic alu_random(input logic [5:0] ctrl);
    logic [63:0] a;
    logic [63:0] b;
    repeat (3) begin
      rand64(a);
      rand64(b);
      alu_once(ctrl, a, b, 64'd0, 1'b0, alu_model(ctrl, a, b));
    end
  endtask

  // a branch or jump followed by one instruction on the wrong path.
  task automatic check_redirect(input logic [5:0] ctrl, input logic [3:0] br,
                                input logic [63:0] pc, input logic [63:0] a,
                                input logic [63:0] b, input logic [63:0] imm,
                                input logic use_imm, input logic exp_taken,
                                input logic [63:0] exp_target, input logic is_jump);
    issue(ctrl, br, pc, a, b, imm, use_imm, 5'd1, 5'd2, 5'd9);
    issue(ADD, BR_NONE, pc + 64'd4, 64'd1, 64'd2, 64'd0, 1'b0, 5'd3, 5'd4, 5'd10);
    @(negedge i_clk);
    compare("o_valid", 64'd1, o_valid);
    compare("o_redirect", exp_taken, o_redirect);
    if (exp_taken) begin
      compare("o_target", exp_target, o_target);
    end
    if (is_jump) begin
      compare("o_result", pc + 64'd4, o_result);
      compare("o_rd_wr", 64'd1, o_rd_wr);
    end
    idle();
    @(negedge i_clk);
    compare("o_valid", !exp_taken, o_valid);
    compare("o_redirect", 64'd0, o_redirect);
    if (!exp_taken) begin
      compare("o_result", 64'd3, o_result);
    end
  endtask

  task automatic branch_edges(input logic [3:0] op);
    logic [63:0] neg;
    neg = 64'h8000_0000_0000_0000;
    check_redirect(ALU_OFF, op, 64'h1000, neg, 64'd1, 64'h40, 1'b0,
                   branch_model(op, neg, 64'd1), 64'h1040, 1'b0);
    check_redirect(ALU_OFF, op, 64'h1000, 64'd1, neg, 64'h40, 1'b0,
                   branch_model(op, 64'd1, neg), 64'h1040, 1'b0);
    check_redirect(ALU_OFF, op, 64'h1000, 64'd5, 64'd5, 64'h40, 1'b0,
                   branch_model(op, 64'd5, 64'd5), 64'h1040, 1'b0);
  endtask

  task automatic reset_values();
    @(negedge i_clk);
    compare("o_valid", 64'd0, o_valid);
    compare("o_rd_wr", 64'd0, o_rd_wr);
    compare("o_redirect", 64'd0, o_redirect);
  endtask

  task automatic all_alu_ops();
    alu_random(ADD);
    alu_random(SUB);
    alu_random(SLL);
    alu_random(SLT);
    alu_random(SLTU);
    alu_random(XOR);
    alu_random(SRL);
    alu_random(SRA);
    alu_random(OR);
    alu_random(AND);
    alu_random(JALR);
    alu_random(ADDW);
    alu_random(SUBW);
    alu_random(SLLW);
    alu_random(SRLW);
    alu_random(SRAW);
  endtask

  task automatic disabled_alu();
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] c;
    rand64(a);
    rand64(b);
    rand64(c);
    alu_once(6'b000101, a, b, 64'd0, 1'b0, 64'd0);
    alu_once(6'b101111, a, b, 64'd0, 1'b0, 64'd0);
    alu_once(ALU_OFF, a, b, 64'd0, 1'b0, 64'd0);
    alu_once(ADD, a, b, c, 1'b1, a + c);
    alu_once(XOR, a, b, c, 1'b1, a ^ c);
  endtask

  task automatic forwarding();
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] w;
    rand64(a);
    rand64(b);
    rand64(w);
    // dependent pair, both sources from ex/mem.
    issue(ADD, BR_NONE, 64'd0, a, b, 64'd0, 1'b0, 5'd1, 5'd2, 5'd5);
    issue(ADD, BR_NONE, 64'd0, 64'hdead, 64'hbeef, 64'd0, 1'b0, 5'd5, 5'd5, 5'd6);
    @(negedge i_clk);
    compare("o_result", a + b, o_result);
    idle();
    @(negedge i_clk);
    compare("o_result", (a + b) + (a + b), o_result);
    // write-back port only.
    issue(ADD, BR_NONE, 64'd0, 64'hdead, b, 64'd0, 1'b0, 5'd7, 5'd2, 5'd11);
    i_wb_rd_addr <= 5'd7;
    i_wb_result  <= w;
    i_wb_wr      <= 1'b1;
    idle();
    @(negedge i_clk);
    compare("o_result", w + b, o_result);
    // both match, ex/mem wins.
    issue(ADD, BR_NONE, 64'd0, a, b, 64'd0, 1'b0, 5'd1, 5'd2, 5'd8);
    issue(ADD, BR_NONE, 64'd0, 64'hdead, b, 64'd0, 1'b0, 5'd8, 5'd2, 5'd12);
    i_wb_rd_addr <= 5'd8;
    i_wb_result  <= w;
    i_wb_wr      <= 1'b1;
    idle();
    @(negedge i_clk);
    compare("o_result", a + b + b, o_result);
    // x0 written by both paths still reads the register file value.
    issue(ADD, BR_NONE, 64'd0, a, b, 64'd0, 1'b0, 5'd1, 5'd2, 5'd0);
    issue(ADD, BR_NONE, 64'd0, 64'h77, b, 64'd0, 1'b0, 5'd0, 5'd2, 5'd13);
    i_wb_rd_addr <= 5'd0;
    i_wb_result  <= w;
    i_wb_wr      <= 1'b1;
    idle();
    @(negedge i_clk);
    compare("o_result", 64'h77 + b, o_result);
  endtask

  task automatic branches();
    branch_edges(BR_BEQ);
    branch_edges(BR_BNE);
    branch_edges(BR_BLT);
    branch_edges(BR_BGE);
    branch_edges(BR_BLTU);
    branch_edges(BR_BGEU);
  endtask

  task automatic jumps();
    logic [63:0] a;
    rand64(a);
    a[0] = 1'b1;
    check_redirect(ALU_OFF, BR_JAL, 64'h2000, a, 64'd0, 64'h100, 1'b0, 1'b1, 64'h2100, 1'b1);
    check_redirect(JALR, BR_JALR, 64'h2000, a, 64'd0, 64'h20, 1'b1, 1'b1,
                   (a + 64'h20) & ~64'd1, 1'b1);
  endtask

  task automatic stall_flush();
    logic [63:0] a;
    logic [63:0] b;
    rand64(a);
    rand64(b);
    issue(ADD, BR_NONE, 64'd0, a, b, 64'd0, 1'b0, 5'd1, 5'd2, 5'd3);
    issue(SUB, BR_NONE, 64'd0, a, b, 64'd0, 1'b0, 5'd1, 5'd2, 5'd4);
    i_stall <= 1'b1;
    repeat (4) begin
      @(negedge i_clk);
      compare("o_result", a + b, o_result);
      compare("o_rd_addr", 64'd3, o_rd_addr);
      compare("o_valid", 64'd1, o_valid);
    end
    @(posedge i_clk);
    i_stall <= 1'b0;
    idle();
    @(negedge i_clk);
    compare("o_result", a - b, o_result);
    compare("o_rd_addr", 64'd4, o_rd_addr);
    // taken branch flushed while stalled.
    issue(ALU_OFF, BR_BEQ, 64'h4000, a, a, 64'h80, 1'b0, 5'd1, 5'd2, 5'd9);
    @(posedge i_clk);
    i_valid     <= 1'b0;
    i_branch_op <= BR_NONE;
    i_stall     <= 1'b1;
    i_flush     <= 1'b1;
    @(negedge i_clk);
    compare("o_redirect", 64'd1, o_redirect);
    compare("o_target", 64'h4080, o_target);
    @(negedge i_clk);
    compare("o_valid", 64'd0, o_valid);
    compare("o_redirect", 64'd0, o_redirect);
    @(posedge i_clk);
    i_stall <= 1'b0;
    i_flush <= 1'b0;
  endtask

  initial begin : watchdog
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge i_clk);
      cycles++;
    end
    $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
    $display("tests failed");
    $finish;
  end

  initial begin
    seed         = 32'ha1e9;
    errors       = 0;
    checks       = 0;
    i_rst        = 1'b1;
    i_valid      = 1'b0;
    i_alu_ctrl   = ALU_OFF;
    i_branch_op  = BR_NONE;
    i_pc         = '0;
    i_rs1_data   = '0;
    i_rs2_data   = '0;
    i_imm        = '0;
    i_use_imm    = 1'b0;
    i_rs1_addr   = '0;
    i_rs2_addr   = '0;
    i_rd_addr    = '0;
    i_rd_wr      = 1'b0;
    i_wb_rd_addr = '0;
    i_wb_result  = '0;
    i_wb_wr      = 1'b0;
    i_stall      = 1'b0;
    i_flush      = 1'b0;
    repeat (10) @(posedge i_clk);
    i_rst <= 1'b0;
    reset_values();
    all_alu_ops();
    disabled_alu();
    forwarding();
    branches();
    jumps();
    stall_flush();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
riscv_pkg.sv
riscv_ex_mem_if.sv
riscv_alu.sv
riscv_forward_unit.sv
riscv_branch_unit.sv
riscv_ex_mem_reg.sv
riscv_execute_stage.sv
tb_riscv_execute_stage.sv

// File: Bender.yml
package:
  name: riscv_execute_stage

sources:
  - riscv_pkg.sv
  - riscv_ex_mem_if.sv
  - riscv_alu.sv
  - riscv_forward_unit.sv
  - riscv_branch_unit.sv
  - riscv_ex_mem_reg.sv
  - riscv_execute_stage.sv
  - target: test
    files:
      - tb_riscv_execute_stage.sv
